// File: common/trellisProbePkg.sv
`default_nettype none

package trellisProbePkg;

   // ---------------------------------------------------------------------
   // data path widths
   // ---------------------------------------------------------------------

   // I/Q sample width from the front end
   localparam int SampleBits = 18;
   // DAC word, full scale at the top bit
   localparam int DacBits = 18;
   // decoder phase error, signed
   localparam int PhaseErrBits = 8;
   // path-metric index from the trellis
   localparam int IndexBits = 6;

   // ---------------------------------------------------------------------
   // register bus
   // ---------------------------------------------------------------------

   localparam int AddrBits = 12;
   localparam int DataBits = 32;

   // trellis block, matched on addr 11..4
   localparam logic [AddrBits-1:0] TrellisSpace = 12'h500;
   // decay factor for the path metrics
   localparam logic [AddrBits-1:0] TrellisDecayAddr = 12'h500;

   // ---------------------------------------------------------------------
   // DAC tap select codes
   // ---------------------------------------------------------------------

   // any code not listed falls back to phase error
   localparam logic [3:0] TapI = 4'd0;
   localparam logic [3:0] TapQ = 4'd1;
   localparam logic [3:0] TapPhaseErr = 4'd2;
   localparam logic [3:0] TapIndex = 4'd3;

   // ---------------------------------------------------------------------
   // bundles
   // ---------------------------------------------------------------------

   // one complex sample
   typedef struct packed {
      logic [SampleBits-1:0] i;
      logic [SampleBits-1:0] q;
   } sampleT;

   // one probe word plus its strobe
   typedef struct packed {
      logic [DacBits-1:0] data;
      logic sync;
   } dacTapT;

   // all four probe points, fanned out to every channel
   typedef struct packed {
      dacTapT i;
      dacTapT q;
      dacTapT phaseErr;
      dacTapT index;
   } probeTapsT;

   // address and write data of a bus cycle
   typedef struct packed {
      logic [AddrBits-1:0] addr;
      logic [DataBits-1:0] din;
   } busReqT;

endpackage

`default_nettype wire

// File: dacMux/dacTapSource.sv
`timescale 1ns/100ps
`default_nettype none

// builds the four probe taps shared by the DAC channels
module dacTapSource (
   input wire clk,
   input wire reset,

   // baseband strobes, sym2xEn at twice the symbol rate
   input wire symEn,
   input wire sym2xEn,
   input wire trellisProbePkg::sampleT samples,

   // decoder side, already aligned to symEnOut
   input wire [trellisProbePkg::PhaseErrBits-1:0] phaseError,
   input wire [trellisProbePkg::IndexBits-1:0] index,
   input wire symEnOut,

   output trellisProbePkg::probeTapsT taps
);

   // zero fill below the decoder fields
   localparam int PhErrPad = trellisProbePkg::DacBits - trellisProbePkg::PhaseErrBits;
   localparam int IndexPad = trellisProbePkg::DacBits - trellisProbePkg::IndexBits;

   // ---------------------------------------------------------------------
   // sample latch
   // ---------------------------------------------------------------------

   // I/Q held between 2x strobes
   trellisProbePkg::sampleT sampleLatch;
   // marks the cycle after a latch
   logic sym2xEnDly;

   always_ff @(posedge clk) begin
      if (reset) begin
         sampleLatch <= '0;
         sym2xEnDly <= 1'b0;
      end else begin
         sym2xEnDly <= sym2xEn;
         if (sym2xEn) begin
            sampleLatch <= samples;
         end
      end
   end

   // ---------------------------------------------------------------------
   // tap formatting
   // ---------------------------------------------------------------------

   always_comb begin
      // I and Q pass unchanged, sync lines up with the new latch value
      taps.i.data = sampleLatch.i;
      taps.i.sync = sym2xEnDly;
      taps.q.data = sampleLatch.q;
      taps.q.sync = sym2xEnDly;

      // phase error at the DAC top bits
      taps.phaseErr.data = {phaseError, {PhErrPad{1'b0}}};
      taps.phaseErr.sync = symEnOut;

      // index in bits 17..12, top bit of the old 19-bit word truncated
      taps.index.data = {index, {IndexPad{1'b0}}};
      taps.index.sync = symEnOut;
   end

   // ---------------------------------------------------------------------
   // checks
   // ---------------------------------------------------------------------

   // the 1x strobe must land on a 2x strobe, or the
   // decoder input grid drifts from the latched samples
   symOnHalfSym : assert property (
      @(posedge clk) disable iff (reset)
      symEn |-> sym2xEn
   ) else $error("dacTapSource: symEn without sym2xEn");

endmodule

`default_nettype wire

// File: dacMux/dacChannel.sv
`timescale 1ns/100ps
`default_nettype none

// one DAC test port, picks a tap and registers it
module dacChannel (
   input wire clk,
   input wire reset,

   // every probe point, same for all channels
   input wire trellisProbePkg::probeTapsT taps,
   // tap select code
   input wire [3:0] select,

   // registered word and sync to the DAC pins
   output trellisProbePkg::dacTapT dac
);

   // ---------------------------------------------------------------------
   // tap select
   // ---------------------------------------------------------------------

   trellisProbePkg::dacTapT tapSel;

   always_comb begin
      case (select)
         trellisProbePkg::TapI: begin
            tapSel = taps.i;
         end
         trellisProbePkg::TapQ: begin
            tapSel = taps.q;
         end
         trellisProbePkg::TapPhaseErr: begin
            tapSel = taps.phaseErr;
         end
         trellisProbePkg::TapIndex: begin
            tapSel = taps.index;
         end
         // unused codes show phase error
         default: begin
            tapSel = taps.phaseErr;
         end
      endcase
   end

   // ---------------------------------------------------------------------
   // output register
   // ---------------------------------------------------------------------

   // data and sync move together so the DAC capture stays aligned
   always_ff @(posedge clk) begin
      if (reset) begin
         dac <= '0;
      end else begin
         dac <= tapSel;
      end
   end

   // ---------------------------------------------------------------------
   // checks
   // ---------------------------------------------------------------------

   // strobes upstream are at least two cycles apart, so with a steady
   // select the DAC sync is a single-cycle pulse
   syncIsPulse : assert property (
      @(posedge clk) disable iff (reset)
      (dac.sync && $stable(select)) |=> !dac.sync
   ) else $error("dacChannel: sync high two cycles in a row");

endmodule

`default_nettype wire

// File: rtl/trellisRegs.sv
`timescale 1ns/100ps
`default_nettype none

// trellis register block on the host bus
module trellisRegs (
   input wire clk,
   input wire reset,

   // address and write data
   input wire trellisProbePkg::busReqT busReq,
   // write strobe, sampled on clk
   input wire wr0,

   // path metric decay for the decoder
   output logic [7:0] decayFactor,
   // readback, follows addr in the same cycle
   output logic [trellisProbePkg::DataBits-1:0] dout
);

   // ---------------------------------------------------------------------
   // address decode
   // ---------------------------------------------------------------------

   // block select, upper address bits only
   logic trellisSpace;
   // exact hit on the decay register
   logic decayHit;

   always_comb begin
      trellisSpace = (busReq.addr[11:4] == trellisProbePkg::TrellisSpace[11:4]);
      decayHit = trellisSpace && (busReq.addr == trellisProbePkg::TrellisDecayAddr);
   end

   // ---------------------------------------------------------------------
   // write side
   // ---------------------------------------------------------------------

   // only the low byte of din is kept
   always_ff @(posedge clk) begin
      if (reset) begin
         decayFactor <= 8'd0;
      end else if (wr0 && decayHit) begin
         decayFactor <= busReq.din[7:0];
      end
   end

   // ---------------------------------------------------------------------
   // read side
   // ---------------------------------------------------------------------

   // zero-extended decay, everything else reads 0
   always_comb begin
      dout = '0;
      if (decayHit) begin
         dout[7:0] = decayFactor;
      end
   end

   // ---------------------------------------------------------------------
   // checks
   // ---------------------------------------------------------------------

   // a floating address during a write could hit any register
   writeAddrKnown : assert property (
      @(posedge clk) disable iff (reset)
      wr0 |-> !$isunknown(busReq.addr)
   ) else $error("trellisRegs: unknown address with wr0 high");

endmodule

`default_nettype wire

// File: rtl/trellisProbeTop.sv
`timescale 1ns/100ps
`default_nettype none

// probe and control wrapper around the external trellis decoder
module trellisProbeTop #(
   // number of DAC test ports
   parameter int NumDacs = 3
) (
   input wire clk,
   input wire reset,

   // symbol strobes from the timing loop
   input wire symEn,
   input wire sym2xEn,
   input wire trellisProbePkg::sampleT samples,

   // results from the decoder
   input wire [trellisProbePkg::PhaseErrBits-1:0] phaseError,
   input wire [trellisProbePkg::IndexBits-1:0] index,
   input wire symEnOut,

   // register bus
   input wire trellisProbePkg::busReqT busReq,
   input wire wr0,
   output logic [trellisProbePkg::DataBits-1:0] dout,

   // DAC test ports
   input wire [3:0] dacSelect [NumDacs],
   output trellisProbePkg::dacTapT dac [NumDacs],

   // to the decoder
   output logic [7:0] decayFactor
);

   // ---------------------------------------------------------------------
   // probe tap source
   // ---------------------------------------------------------------------

   // shared by every DAC channel
   trellisProbePkg::probeTapsT taps;

   // carrier loop stays bypassed, samples go straight to the taps
   dacTapSource uTapSource (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .sym2xEn    (sym2xEn),
      .samples    (samples),
      .phaseError (phaseError),
      .index      (index),
      .symEnOut   (symEnOut),
      .taps       (taps)
   );

   // ---------------------------------------------------------------------
   // register port
   // ---------------------------------------------------------------------

   trellisRegs uRegs (
      .clk         (clk),
      .reset       (reset),
      .busReq      (busReq),
      .wr0         (wr0),
      .decayFactor (decayFactor),
      .dout        (dout)
   );

   // ---------------------------------------------------------------------
   // DAC channels
   // ---------------------------------------------------------------------

   // one identical channel per port, each with its own select
   for (genvar ch = 0; ch < NumDacs; ch++) begin : gDac
      dacChannel uDac (
         .clk    (clk),
         .reset  (reset),
         .taps   (taps),
         .select (dacSelect[ch]),
         .dac    (dac[ch])
      );
   end

endmodule

`default_nettype wire

// File: tb/trellisProbeVectors.svh
// columns: select of dac 2, dac 1, dac 0 | strobe kind | phase error | index
// strobe kind 0 is a random I/Q sample on sym2xEn, 1 is a decoder result on symEnOut
// phase error and index only apply to decoder rows

// short names for the select codes
localparam logic [3:0] SelI = trellisProbePkg::TapI;
localparam logic [3:0] SelQ = trellisProbePkg::TapQ;
localparam logic [3:0] SelPe = trellisProbePkg::TapPhaseErr;
localparam logic [3:0] SelIdx = trellisProbePkg::TapIndex;
// undefined codes, expected to fall back to phase error
localparam logic [3:0] SelBadF = 4'hF;
localparam logic [3:0] SelBad7 = 4'h7;
localparam logic [3:0] SelBadC = 4'hC;

// one stimulus row
typedef struct packed {
   logic [2:0][3:0] sel;
   logic decoderRow;
   logic [7:0] phErr;
   logic [5:0] index;
} vectorRowT;

localparam int NumVectors = 12;

localparam vectorRowT Vectors [NumVectors] = '{
   // plain I and Q, one channel parked on phase error
   '{{SelPe, SelQ, SelI}, 1'b0, 8'h00, 6'h00},
   // sign bit of phase error and full-scale index
   '{{SelI, SelIdx, SelPe}, 1'b1, 8'h80, 6'h3F},
   // undefined code next to the real phase error tap
   '{{SelIdx, SelPe, SelBadF}, 1'b1, 8'hFF, 6'h01},
   '{{SelIdx, SelQ, SelQ}, 1'b0, 8'h00, 6'h00},
   '{{SelIdx, SelIdx, SelIdx}, 1'b1, 8'h00, 6'h2A},
   '{{SelBad7, SelQ, SelI}, 1'b0, 8'h00, 6'h00},
   '{{SelPe, SelQ, SelBad7}, 1'b1, 8'h5A, 6'h15},
   '{{SelI, SelI, SelI}, 1'b0, 8'h00, 6'h00},
   // all three on undefined codes
   '{{4'h4, SelBadF, SelBadC}, 1'b1, 8'h01, 6'h00},
   '{{SelI, SelIdx, SelQ}, 1'b0, 8'h00, 6'h00},
   '{{SelIdx, SelI, SelPe}, 1'b1, 8'h7F, 6'h20},
   '{{SelQ, SelPe, SelI}, 1'b0, 8'h00, 6'h00}
};

// File: tb/trellisProbeTb.sv
`timescale 1ns/100ps
`default_nettype none

module trellisProbeTb;

   localparam int NumDacs = 3;
   // cycles allowed for a DAC sync to show up
   localparam int SyncTimeout = 10;

   `include "trellisProbeVectors.svh"

   logic clk;
   logic reset;
   logic symEn;
   logic sym2xEn;
   trellisProbePkg::sampleT samples;
   logic [7:0] phaseError;
   logic [5:0] index;
   logic symEnOut;
   trellisProbePkg::busReqT busReq;
   logic wr0;
   logic [31:0] dout;
   logic [3:0] dacSelect [NumDacs];
   trellisProbePkg::dacTapT dac [NumDacs];
   logic [7:0] decayFactor;

   integer seed = 32'h5536;
   int errorCount = 0;

   // model of what the taps should hold
   trellisProbePkg::sampleT curSample;
   logic [7:0] curPhErr;
   logic [5:0] curIndex;

   trellisProbeTop #(.NumDacs(NumDacs)) DUT (
      .clk         (clk),
      .reset       (reset),
      .symEn       (symEn),
      .sym2xEn     (sym2xEn),
      .samples     (samples),
      .phaseError  (phaseError),
      .index       (index),
      .symEnOut    (symEnOut),
      .busReq      (busReq),
      .wr0         (wr0),
      .dout        (dout),
      .dacSelect   (dacSelect),
      .dac         (dac),
      .decayFactor (decayFactor)
   );

   // 40 ns period
   always #20 clk = ~clk;

   // ---------------------------------------------------------------------
   // error reporting
   // ---------------------------------------------------------------------

   task automatic reportValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      errorCount++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic reportProblem(input string what);
      errorCount++;
      $display("ERROR %s", what);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   // hard stop in case a wait slips past its own timeout
   initial begin
      #2000000;
      reportProblem("simulation ran past its time limit");
   end

   // ---------------------------------------------------------------------
   // expected DAC words
   // ---------------------------------------------------------------------

   function automatic logic [17:0] expectedData(input logic [3:0] sel);
      case (sel)
         4'd0: expectedData = curSample.i;
         4'd1: expectedData = curSample.q;
         // index in bits 17..12
         4'd3: expectedData = {curIndex, 12'd0};
         // phase error and every unknown code in the top 8 bits
         default: expectedData = {curPhErr, 10'd0};
      endcase
   endfunction

   function automatic logic isSampleTap(input logic [3:0] sel);
      isSampleTap = (sel == 4'd0) || (sel == 4'd1);
   endfunction

   // ---------------------------------------------------------------------
   // vector and bus tasks
   // ---------------------------------------------------------------------

   task automatic runVector(input int v);
      vectorRowT row;
      trellisProbePkg::sampleT newSample;
      logic [NumDacs-1:0] active;
      logic found;
      int latency;
      int expLatency;
      row = Vectors[v];
      @(posedge clk);
      for (int ch = 0; ch < NumDacs; ch++) begin
         dacSelect[ch] <= row.sel[ch];
      end
      // let the new selects settle into the channel registers
      @(posedge clk);
      @(posedge clk);
      if (row.decoderRow) begin
         phaseError <= row.phErr;
         index <= row.index;
         symEnOut <= 1'b1;
         curPhErr = row.phErr;
         curIndex = row.index;
         expLatency = 1;
      end else begin
         newSample.i = $random(seed);
         newSample.q = $random(seed);
         samples <= newSample;
         sym2xEn <= 1'b1;
         symEn <= (v % 3 == 0);
         curSample = newSample;
         expLatency = 2;
      end
      // the DUT takes the strobe at this edge
      @(posedge clk);
      sym2xEn <= 1'b0;
      symEn <= 1'b0;
      symEnOut <= 1'b0;
      // move the input away so only the latch can hold the strobed sample
      samples <= ~curSample;
      for (int ch = 0; ch < NumDacs; ch++) begin
         active[ch] = (isSampleTap(row.sel[ch]) != row.decoderRow);
      end
      found = 1'b0;
      latency = 0;
      while (!found && latency < SyncTimeout) begin
         @(negedge clk);
         latency++;
         for (int ch = 0; ch < NumDacs; ch++) begin
            if (active[ch] && dac[ch].sync) begin
               found = 1'b1;
            end
         end
      end
      assert (found) else reportProblem($sformatf("vector %0d never raised a DAC sync", v));
      assert (latency == expLatency)
         else reportValue($sformatf("vector %0d sync latency", v), expLatency, latency);
      for (int ch = 0; ch < NumDacs; ch++) begin
         assert (dac[ch].sync == active[ch])
            else reportValue($sformatf("vector %0d dac %0d sync", v, ch), active[ch],
                             dac[ch].sync);
         assert (dac[ch].data == expectedData(row.sel[ch]))
            else reportValue($sformatf("vector %0d dac %0d data", v, ch),
                             expectedData(row.sel[ch]), dac[ch].data);
      end
   endtask

   task automatic busWrite(input logic [11:0] addr, input logic [31:0] data);
      @(posedge clk);
      busReq <= {addr, data};
      wr0 <= 1'b1;
      @(posedge clk);
      wr0 <= 1'b0;
   endtask

   task automatic checkDecay(input string name, input logic [7:0] expected);
      @(negedge clk);
      assert (decayFactor == expected) else reportValue(name, expected, decayFactor);
   endtask

   task automatic checkRead(input string name, input logic [11:0] addr,
                            input logic [31:0] expected);
      @(posedge clk);
      busReq.addr <= addr;
      @(negedge clk);
      assert (dout == expected) else reportValue(name, expected, dout);
   endtask

   // ---------------------------------------------------------------------
   // main sequence
   // ---------------------------------------------------------------------

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      symEn = 1'b0;
      sym2xEn = 1'b0;
      samples = '0;
      phaseError = '0;
      index = '0;
      symEnOut = 1'b0;
      busReq = {trellisProbePkg::TrellisDecayAddr, 32'd0};
      wr0 = 1'b0;
      for (int ch = 0; ch < NumDacs; ch++) begin
         dacSelect[ch] = 4'd0;
      end
      curSample = '0;
      curPhErr = '0;
      curIndex = '0;

      // reset state checked while reset is still high
      repeat (4) @(posedge clk);
      @(negedge clk);
      for (int ch = 0; ch < NumDacs; ch++) begin
         assert (dac[ch] == '0)
            else reportValue($sformatf("reset dac %0d", ch), 32'd0, dac[ch]);
      end
      assert (decayFactor == 8'd0) else reportValue("reset decayFactor", 0, decayFactor);
      assert (dout == 32'd0) else reportValue("reset dout", 0, dout);
      @(posedge clk);
      reset <= 1'b0;

      for (int v = 0; v < NumVectors; v++) begin
         runVector(v);
      end

      // register port
      busWrite(12'h500, 32'hABCD_125A);
      checkDecay("decay after write", 8'h5A);
      checkRead("read decay", 12'h500, 32'h0000_005A);
      busWrite(12'h501, 32'h0000_0033);
      checkDecay("decay after write to 0x501", 8'h5A);
      busWrite(12'h400, 32'hFFFF_FFFF);
      checkDecay("decay after write to 0x400", 8'h5A);
      checkRead("read 0x501", 12'h501, 32'd0);
      checkRead("read 0x600", 12'h600, 32'd0);
      busWrite(12'h500, 32'h1234_56C3);
      checkDecay("decay after second write", 8'hC3);
      checkRead("read decay again", 12'h500, 32'h0000_00C3);

      if (errorCount == 0) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+tb
common/trellisProbePkg.sv
dacMux/dacTapSource.sv
dacMux/dacChannel.sv
rtl/trellisRegs.sv
rtl/trellisProbeTop.sv
tb/trellisProbeTb.sv
